//--- color_bars.sv
`timescale 1ns/1ps

module color_bars #(
	parameter int bar_width = 50
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              blank,
	output tmds_pkg::pixel_t  red,
	output tmds_pkg::pixel_t  green,
	output tmds_pkg::pixel_t  blue
);

	import tmds_pkg::*;

	localparam int pw = $clog2(bar_width + 1);
	localparam int bw = $clog2(bar_count);

	logic [pw-1:0] pix_cnt; // position inside the current bar
	logic [bw-1:0] bar_cnt; // palette index
	logic          bar_wrap;
	logic          last_bar;

	assign bar_wrap = (pix_cnt == pw'(bar_width - 1));
	assign last_bar = (bar_cnt == bw'(bar_count - 1));

	// both counters restart on every blanking interval
	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			bar_cnt <= '0;
		end else if (blank) begin
			pix_cnt <= '0;
			bar_cnt <= '0;
		end else begin
			if (bar_wrap) begin
				pix_cnt <= '0;
				if (!last_bar)
					bar_cnt <= bar_cnt + 1'b1; // saturate on black
			end else begin
				pix_cnt <= pix_cnt + 1'b1;
			end
		end
	end

	// palette lookup straight off the bar counter
	assign {red, green, blue} = bar_palette[bar_cnt];

endmodule

//--- dvi_source.sv
`timescale 1ns/1ps

module dvi_source #(
	parameter int h_active  = 640,
	parameter int h_front   = 16,
	parameter int h_sync    = 96,
	parameter int h_back    = 48,
	parameter int v_active  = 480,
	parameter int v_front   = 10,
	parameter int v_sync    = 2,
	parameter int v_back    = 33,
	parameter int bar_width = 50
) (
	input  logic              clk,
	input  logic              reset,
	output tmds_pkg::symbol_t tmds_red,
	output tmds_pkg::symbol_t tmds_green,
	output tmds_pkg::symbol_t tmds_blue
);

	import tmds_pkg::*;

	logic   blank;
	logic   hsync;
	logic   vsync;
	pixel_t red;
	pixel_t green;
	pixel_t blue;

	video_timing #(
		.h_active (h_active),
		.h_front  (h_front),
		.h_sync   (h_sync),
		.h_back   (h_back),
		.v_active (v_active),
		.v_front  (v_front),
		.v_sync   (v_sync),
		.v_back   (v_back)
	) i_video_timing (
		.clk   (clk),
		.reset (reset),
		.blank (blank),
		.hsync (hsync),
		.vsync (vsync)
	);

	color_bars #(
		.bar_width (bar_width)
	) i_color_bars (
		.clk   (clk),
		.reset (reset),
		.blank (blank),
		.red   (red),
		.green (green),
		.blue  (blue)
	);

	// red and green send control pair zero
	tmds_encoder #(
		.ctrl_fixed (2'b00),
		.use_sync   (1'b0)
	) i_enc_red (
		.clk    (clk),
		.reset  (reset),
		.blank  (blank),
		.hsync  (hsync),
		.vsync  (vsync),
		.data   (red),
		.symbol (tmds_red)
	);

	tmds_encoder #(
		.ctrl_fixed (2'b00),
		.use_sync   (1'b0)
	) i_enc_green (
		.clk    (clk),
		.reset  (reset),
		.blank  (blank),
		.hsync  (hsync),
		.vsync  (vsync),
		.data   (green),
		.symbol (tmds_green)
	);

	tmds_encoder #(
		.ctrl_fixed (2'b00),
		.use_sync   (1'b1) // syncs ride on blue
	) i_enc_blue (
		.clk    (clk),
		.reset  (reset),
		.blank  (blank),
		.hsync  (hsync),
		.vsync  (vsync),
		.data   (blue),
		.symbol (tmds_blue)
	);

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_dvi_source -f verilog.f; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_dvi_source 2>&1)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qxF '>>> PASS' <<< "$sim_out"; then
	exit 0
fi

echo "pass line not found in simulation output"
exit 1

//--- tb_dvi_source.sv
`timescale 1ns/1ps

module tb_dvi_source;

	import tmds_pkg::*;

	// small raster so two frames run quickly
	localparam int h_active  = 40;
	localparam int h_front   = 4;
	localparam int h_sync    = 6;
	localparam int h_back    = 4;
	localparam int v_active  = 6;
	localparam int v_front   = 1;
	localparam int v_sync    = 2;
	localparam int v_back    = 2;
	localparam int bar_width = 3;

	localparam int h_total       = h_active + h_front + h_sync + h_back;
	localparam int v_total       = v_active + v_front + v_sync + v_back;
	localparam int frame_cycles  = h_total * v_total;
	localparam int timeout_limit = 4 * frame_cycles;
	localparam int balance_limit = 20;

	logic    clk;
	logic    reset;
	symbol_t tmds_red;
	symbol_t tmds_green;
	symbol_t tmds_blue;
	logic    running; // reset seen low on a rising edge

	// reference raster position of the symbols now on the outputs
	int ref_h;
	int ref_v;
	bit ref_blank;
	bit ref_hs;
	bit ref_vs;

	symbol_t got_sym [3]; // raw token, or decoded pixel during active video
	symbol_t exp_sym [3];
	int      bal     [3]; // ones minus zeros since the last control period

	bit checks_on   = 1'b0;
	bit first_cycle = 1'b0;
	bit in_frame    = 1'b0;
	bit prev_data   = 1'b0;
	bit seen_start  = 1'b0;
	bit hs_done     = 1'b0;
	bit line_done   = 1'b0;
	bit line_start  = 1'b0;
	bit frame_start = 1'b0;
	bit frame_done  = 1'b0;

	int cycle_no;
	int hs_len;
	int hs_last;
	int hs_runs;
	int line_runs;
	int line_gap;
	int line_gap_seen;
	int frame_gap;
	int frame_gap_seen;
	int vs_cycles;
	int frame_vs;
	int frames_done;

	dvi_source #(
		.h_active  (h_active),
		.h_front   (h_front),
		.h_sync    (h_sync),
		.h_back    (h_back),
		.v_active  (v_active),
		.v_front   (v_front),
		.v_sync    (v_sync),
		.v_back    (v_back),
		.bar_width (bar_width)
	) i_dvi_source (
		.clk        (clk),
		.reset      (reset),
		.tmds_red   (tmds_red),
		.tmds_green (tmds_green),
		.tmds_blue  (tmds_blue)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	function automatic string chan_name(input int c);
		case (c)
			0:       return "tmds_red";
			1:       return "tmds_green";
			default: return "tmds_blue";
		endcase
	endfunction

	// dvi receive rule, undo the inversion and then the chain
	function automatic pixel_t decode_symbol(input symbol_t s);
		logic [7:0] q;
		pixel_t     d;
		q    = s[9] ? ~s[7:0] : s[7:0];
		d[0] = q[0];
		for (int i = 1; i < 8; i++) begin
			d[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
		end
		return d;
	endfunction

	function automatic ctrl_token_t token_for_pair(input logic [1:0] pair);
		ctrl_token_t t;
		case (pair)
			2'b00:   t = ctrl_00;
			2'b01:   t = ctrl_01;
			2'b10:   t = ctrl_10;
			default: t = ctrl_11;
		endcase
		return t;
	endfunction

	function automatic bit is_control(input symbol_t s);
		return (s == ctrl_00) || (s == ctrl_01) || (s == ctrl_10) || (s == ctrl_11);
	endfunction

	function automatic int ones_in_symbol(input symbol_t s);
		int n;
		n = 0;
		for (int i = 0; i < 10; i++) begin
			n = n + int'(s[i]);
		end
		return n;
	endfunction

	always @(posedge clk) begin
		running <= !reset;
	end

	// reference model, updated while the outputs are stable
	always @(negedge clk) begin
		symbol_t     sym [3];
		logic [23:0] colour;
		int          bar;
		bit          data_now;
		bit          hs_now;
		bit          vs_now;

		sym[0] = tmds_red;
		sym[1] = tmds_green;
		sym[2] = tmds_blue;
		if (!running) begin
			ref_h       = h_total - 2; // one step lands on the reset state
			ref_v       = v_total - 1;
			cycle_no    = 0;
			checks_on   = 1'b0;
			first_cycle = 1'b0;
			hs_len      = 0;
			hs_runs     = 0;
			line_gap    = 0;
			frame_gap   = 0;
			vs_cycles   = 0;
			frames_done = 0;
			for (int c = 0; c < 3; c++) begin
				bal[c] = 0;
			end
		end else begin
			if (ref_h == h_total - 1) begin
				ref_h = 0;
				ref_v = (ref_v == v_total - 1) ? 0 : ref_v + 1;
			end else begin
				ref_h = ref_h + 1;
			end
			ref_blank   = (ref_h >= h_active) || (ref_v >= v_active);
			ref_hs      = (ref_h >= h_active + h_front) && (ref_h < h_active + h_front + h_sync);
			ref_vs      = (ref_v >= v_active + v_front) && (ref_v < v_active + v_front + v_sync);
			checks_on   = 1'b1;
			first_cycle = (cycle_no == 0);
			cycle_no    = cycle_no + 1;
			if (ref_h == 0 && ref_v == 0)
				in_frame = 1'b1;

			data_now = !is_control(sym[0]);
			for (int c = 0; c < 3; c++) begin
				if (ref_blank) begin
					exp_sym[c] = (c == 2) ? token_for_pair({~ref_vs, ~ref_hs}) : ctrl_00;
					got_sym[c] = sym[c];
				end else begin
					bar = ref_h / bar_width;
					if (bar > bar_count - 1)
						bar = bar_count - 1; // black after the last bar
					colour     = bar_palette[bar];
					exp_sym[c] = {2'b00, colour[23 - 8 * c -: 8]};
					got_sym[c] = {2'b00, decode_symbol(sym[c])};
				end
				if (data_now)
					bal[c] = bal[c] + 2 * ones_in_symbol(sym[c]) - 10;
				else
					bal[c] = 0;
			end

			// hsync runs, inverted hsync bit low on blue
			hs_now  = (sym[2] == ctrl_00) || (sym[2] == ctrl_10);
			hs_done = 1'b0;
			if (hs_now) begin
				hs_len = hs_len + 1;
			end else if (hs_len != 0) begin
				hs_done = 1'b1;
				hs_last = hs_len;
				hs_len  = 0;
				hs_runs = hs_runs + 1;
			end
			line_done = in_frame && (ref_h == h_total - 1);
			if (ref_h == h_total - 1) begin
				line_runs = hs_runs;
				hs_runs   = 0;
			end

			// spacing of the first data symbol of each line
			line_gap    = line_gap + 1;
			frame_gap   = frame_gap + 1;
			line_start  = 1'b0;
			frame_start = 1'b0;
			if (data_now && !prev_data) begin
				if (ref_v != 0) begin
					line_start    = 1'b1;
					line_gap_seen = line_gap;
				end else if (seen_start) begin
					frame_start    = 1'b1;
					frame_gap_seen = frame_gap;
				end
				if (ref_v == 0) begin
					seen_start = 1'b1;
					frame_gap  = 0;
				end
				line_gap = 0;
			end
			prev_data = data_now;

			// vsync cycles per frame
			vs_now = (sym[2] == ctrl_00) || (sym[2] == ctrl_01);
			if (vs_now)
				vs_cycles = vs_cycles + 1;
			frame_done = in_frame && (ref_h == h_total - 1) && (ref_v == v_total - 1);
			if (frame_done) begin
				frame_vs    = vs_cycles;
				vs_cycles   = 0;
				frames_done = frames_done + 1;
			end
		end
	end

	for (genvar c = 0; c < 3; c++) begin : g_chan
		localparam symbol_t idle_token = (c == 2) ? ctrl_11 : ctrl_00;

		assert property (@(posedge clk) !first_cycle || got_sym[c] == idle_token)
			else stop_with_error($sformatf("mismatch at %0t: %s after reset expected %h got %h",
				$time, chan_name(c), idle_token, got_sym[c]));

		assert property (@(posedge clk) !checks_on || got_sym[c] == exp_sym[c])
			else stop_with_error($sformatf("mismatch at %0t: %s at x %0d y %0d expected %h got %h",
				$time, chan_name(c), ref_h, ref_v, exp_sym[c], got_sym[c]));

		assert property (@(posedge clk)
			!checks_on || (bal[c] >= -balance_limit && bal[c] <= balance_limit))
			else stop_with_error($sformatf("%s running balance of %0d went out of range at %0t",
				chan_name(c), bal[c], $time));
	end

	assert property (@(posedge clk) !hs_done || hs_last == h_sync)
		else stop_with_error($sformatf("mismatch at %0t: hsync_run_length expected %0d got %0d",
			$time, h_sync, hs_last));

	assert property (@(posedge clk) !line_done || line_runs == 1)
		else stop_with_error($sformatf("mismatch at %0t: hsync_runs_per_line expected 1 got %0d",
			$time, line_runs));

	assert property (@(posedge clk) !line_start || line_gap_seen == h_total)
		else stop_with_error($sformatf("mismatch at %0t: line_start_gap expected %0d got %0d",
			$time, h_total, line_gap_seen));

	assert property (@(posedge clk) !frame_start || frame_gap_seen == frame_cycles)
		else stop_with_error($sformatf("mismatch at %0t: frame_start_gap expected %0d got %0d",
			$time, frame_cycles, frame_gap_seen));

	assert property (@(posedge clk) !frame_done || frame_vs == v_sync * h_total)
		else stop_with_error($sformatf("mismatch at %0t: vsync_cycles expected %0d got %0d",
			$time, v_sync * h_total, frame_vs));

	initial begin
		int waited;
		reset = 1'b1;
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset  = 1'b0;
		waited = 0;
		while (frames_done < 2 && waited < timeout_limit) begin
			@(posedge clk);
			waited = waited + 1;
		end
		@(negedge clk); // checks on the last rising edge have run
		if (frames_done >= 2) begin
			$display(">>> PASS");
			$finish;
		end else begin
			stop_with_error("timed out waiting for two complete video frames");
		end
	end

endmodule

//--- tmds_encoder.sv
`timescale 1ns/1ps

module tmds_encoder #(
	parameter logic [1:0] ctrl_fixed = 2'b00,
	parameter bit         use_sync   = 1'b0
) (
	input  logic              clk,
	input  logic              reset,
	input  logic              blank,
	input  logic              hsync,
	input  logic              vsync,
	input  tmds_pkg::pixel_t  data,
	output tmds_pkg::symbol_t symbol
);

	import tmds_pkg::*;

	logic [1:0]  ctrl;      // {c1, c0}
	ctrl_token_t token;
	logic [3:0]  data_ones;
	logic        use_xnor;
	logic [8:0]  q_m;       // transition minimised word
	disparity_t  word_disp; // (ones - zeros) / 2 of q_m[7:0]
	disparity_t  disp;      // running balance, same units

	// blue carries the syncs inverted, the others a fixed pair
	assign ctrl = use_sync ? {~vsync, ~hsync} : ctrl_fixed;

	always_comb begin
		case (ctrl)
			2'b00:   token = ctrl_00;
			2'b01:   token = ctrl_01;
			2'b10:   token = ctrl_10;
			default: token = ctrl_11;
		endcase
	end

	// stage 1, pick the chain that gives fewer transitions
	assign data_ones = count_ones(data);
	assign use_xnor  = (data_ones > 4'd4) || ((data_ones == 4'd4) && !data[0]);

	always_comb begin
		q_m[0] = data[0];
		for (int i = 1; i < pixel_w; i++) begin
			if (use_xnor)
				q_m[i] = q_m[i-1] ~^ data[i];
			else
				q_m[i] = q_m[i-1] ^ data[i];
		end
		q_m[8] = ~use_xnor; // 1 marks the xor chain
	end

	// ones minus four, wraps correctly in four bits
	assign word_disp = disparity_t'(count_ones(q_m[7:0]) - 4'd4);

	// stage 2, dc balance against the running disparity
	always_ff @(posedge clk) begin
		if (reset || blank) begin
			symbol <= token;
			disp   <= '0; // balance restarts each control period
		end else if (disp == 0 || word_disp == 0) begin
			// no preference, bit 9 just follows the chain type
			if (q_m[8]) begin
				symbol <= {2'b01, q_m[7:0]};
				disp   <= disp + word_disp;
			end else begin
				symbol <= {2'b10, ~q_m[7:0]};
				disp   <= disp - word_disp;
			end
		end else if (disp[3] == word_disp[3]) begin
			// same sign would grow the imbalance, so invert
			symbol <= {1'b1, q_m[8], ~q_m[7:0]};
			disp   <= disp + disparity_t'({3'b000, q_m[8]}) - word_disp;
		end else begin
			symbol <= {1'b0, q_m[8], q_m[7:0]};
			disp   <= disp - disparity_t'({3'b000, ~q_m[8]}) + word_disp;
		end
	end

endmodule

//--- tmds_pkg.sv
package tmds_pkg;

	localparam int pixel_w  = 8;
	localparam int symbol_w = 10;

	typedef logic [pixel_w-1:0]  pixel_t;  // one colour component
	typedef logic [symbol_w-1:0] symbol_t; // one channel symbol per pixel clock

	// half-unit balance of ones against zeros on the wire
	typedef logic signed [3:0] disparity_t;

	// control period tokens, named after their {c1, c0} pair
	typedef enum logic [symbol_w-1:0] {
		ctrl_00 = 10'b1101010100,
		ctrl_01 = 10'b0010101011,
		ctrl_10 = 10'b0101010100,
		ctrl_11 = 10'b1010101011
	} ctrl_token_t;

	localparam int bar_count = 14;

	// smpte style bars, packed as {red, green, blue}
	localparam logic [23:0] bar_palette [bar_count] = '{
		24'hc0c0c0, // grey
		24'hc0c000, // yellow
		24'h00c000, // green
		24'h00c0c0, // cyan
		24'hc000c0, // magenta
		24'hc00000, // red
		24'h0000c0, // blue
		24'h131313,
		24'h00214c, // -i
		24'hffffff, // white
		24'h32006a, // +q
		24'h090909, // pluge steps
		24'h1d1d1d,
		24'h000000  // black, held after the last bar
	};

	// number of set bits in one byte
	function automatic logic [3:0] count_ones(input pixel_t b);
		logic [3:0] n;
		n = '0;
		for (int i = 0; i < pixel_w; i++) begin
			n = n + {3'b000, b[i]};
		end
		return n;
	endfunction

endpackage

//--- verilog.f
tmds_pkg.sv
video_timing.sv
color_bars.sv
tmds_encoder.sv
dvi_source.sv
tb_dvi_source.sv

//--- video_timing.sv
`timescale 1ns/1ps

module video_timing #(
	parameter int h_active = 640,
	parameter int h_front  = 16,
	parameter int h_sync   = 96,
	parameter int h_back   = 48,
	parameter int v_active = 480,
	parameter int v_front  = 10,
	parameter int v_sync   = 2,
	parameter int v_back   = 33
) (
	input  logic clk,
	input  logic reset,
	output logic blank,
	output logic hsync,
	output logic vsync
);

	localparam int h_total = h_active + h_front + h_sync + h_back;
	localparam int v_total = v_active + v_front + v_sync + v_back;
	localparam int hw      = $clog2(h_total);
	localparam int vw      = $clog2(v_total);

	// sync windows measured from the start of the line / frame
	localparam int h_sync_start = h_active + h_front;
	localparam int h_sync_end   = h_sync_start + h_sync;
	localparam int v_sync_start = v_active + v_front;
	localparam int v_sync_end   = v_sync_start + v_sync;

	logic [hw-1:0] hcnt;
	logic [vw-1:0] vcnt;
	logic          line_end;

	assign line_end = (hcnt == hw'(h_total - 1));

	// free running raster counters
	always_ff @(posedge clk) begin
		if (reset) begin
			hcnt <= '0;
			vcnt <= '0;
		end else begin
			if (line_end) begin
				hcnt <= '0;
				if (vcnt == vw'(v_total - 1))
					vcnt <= '0;
				else
					vcnt <= vcnt + 1'b1;
			end else begin
				hcnt <= hcnt + 1'b1;
			end
		end
	end

	// registered, so these trail the counters by one clock
	always_ff @(posedge clk) begin
		if (reset) begin
			blank <= 1'b1; // come out of reset blanked
			hsync <= 1'b0;
			vsync <= 1'b0;
		end else begin
			blank <= (hcnt >= hw'(h_active)) || (vcnt >= vw'(v_active));
			hsync <= (hcnt >= hw'(h_sync_start)) && (hcnt < hw'(h_sync_end));
			vsync <= (vcnt >= vw'(v_sync_start)) && (vcnt < vw'(v_sync_end));
		end
	end

endmodule
